// File: sim.f
source/sram_pkg.sv
source/sram_port_arbiter.sv
source/sram_sequencer.sv
source/sram_ctrl_top.sv
testbench/sram_model.sv
testbench/tb_sram_ctrl.sv

// File: Makefile
# Verilator build and run for the SRAM controller testbench

VERILATOR ?= verilator
TOP       ?= tb_sram_ctrl
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= all tests passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The output goes to the terminal and is searched for the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		exit 0; \
	else \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/tb_sram_ctrl.sv
module tb_sram_ctrl import sram_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// Accesses over all tests plus cycles for reset, the idle test and slack
	localparam int access_count = 78;
	localparam int cycle_margin = 100;
	localparam int cycle_limit  = access_count * (4 * phase_cycles + 4) + cycle_margin;

	logic           clk = 1'b0;
	logic           rst;
	mem_addr_t      fetch_addr;
	req_tag_t       fetch_tag;
	mem_word_t      fetch_data;
	logic           fetch_done;
	mem_addr_t      exe_addr;
	mem_word_t      exe_wdata;
	logic           exe_write;
	req_tag_t       exe_tag;
	mem_word_t      exe_rdata;
	logic           exe_done;
	mem_addr_t      sram_addr;
	wire mem_word_t sram_data;
	logic           sram_en_n;
	logic           sram_oe_n;
	logic           sram_we_n;

	logic [15:0] lfsr_state = 16'd77;
	int          cycles = 0;

	// Expected memory contents and the addresses written so far
	mem_word_t shadow [mem_addr_t];
	mem_addr_t written [$];

	sram_ctrl_top i_dut (
		.clk        (clk),
		.rst        (rst),
		.fetch_addr (fetch_addr),
		.fetch_tag  (fetch_tag),
		.fetch_data (fetch_data),
		.fetch_done (fetch_done),
		.exe_addr   (exe_addr),
		.exe_wdata  (exe_wdata),
		.exe_write  (exe_write),
		.exe_tag    (exe_tag),
		.exe_rdata  (exe_rdata),
		.exe_done   (exe_done),
		.sram_addr  (sram_addr),
		.sram_data  (sram_data),
		.sram_en_n  (sram_en_n),
		.sram_oe_n  (sram_oe_n),
		.sram_we_n  (sram_we_n)
	);

	sram_model i_sram (
		.sram_addr (sram_addr),
		.sram_data (sram_data),
		.sram_en_n (sram_en_n),
		.sram_oe_n (sram_oe_n),
		.sram_we_n (sram_we_n)
	);

	always #4 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Failure handling and checks
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "run stopped at the first error");
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
			abort_run($sformatf("timeout after %0d cycles, a done level never rose", cycles));
	end

	task automatic check_word(input string name, input mem_word_t got, input mem_word_t exp);
		if (got !== exp)
			abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
		if (got !== exp)
			abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Port accesses
	////////////////////////////////////////////////////////////////////////////

	// New tag starts the access and done comes back when it is served
	task automatic exe_access(input logic wr, input mem_addr_t addr, input mem_word_t data);
		@(posedge clk);
		exe_addr  <= addr;
		exe_wdata <= data;
		exe_write <= wr;
		exe_tag   <= exe_tag + 1'b1;
		@(negedge clk);
		while (!exe_done) begin
			// Pins carry this access while a strobe is low
			if (!sram_oe_n || !sram_we_n)
				check_addr("sram_addr", sram_addr, addr);
			if (!sram_we_n)
				check_word("sram_data", sram_data, data);
			@(negedge clk);
		end
	endtask

	task automatic fetch_access(input mem_addr_t addr);
		@(posedge clk);
		fetch_addr <= addr;
		fetch_tag  <= fetch_tag + 1'b1;
		@(negedge clk);
		while (!fetch_done) begin
			if (!sram_oe_n || !sram_we_n)
				check_addr("sram_addr", sram_addr, addr);
			@(negedge clk);
		end
	endtask

	task automatic exe_store(input mem_addr_t addr, input mem_word_t data);
		exe_access(1'b1, addr, data);
		shadow[addr] = data;
		written.push_back(addr);
	endtask

	task automatic exe_load(input mem_addr_t addr);
		exe_access(1'b0, addr, '0);
		check_word("exe_rdata", exe_rdata, shadow[addr]);
	endtask

	task automatic fetch_load(input mem_addr_t addr);
		fetch_access(addr);
		check_word("fetch_data", fetch_data, shadow[addr]);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic reset_state();
		@(negedge clk);
		check_bit("sram_we_n", sram_we_n, 1'b1);
		check_bit("sram_oe_n", sram_oe_n, 1'b1);
		check_bit("sram_en_n", sram_en_n, 1'b0);
		check_bit("fetch_done", fetch_done, 1'b1);
		check_bit("exe_done", exe_done, 1'b1);
	endtask

	task automatic exe_write_read();
		exe_store(18'h0_1234, 16'hbeef);
		exe_load(18'h0_1234);
		// Top word of the chip
		exe_store(18'h3_ffff, 16'h5aa5);
		exe_load(18'h3_ffff);
	endtask

	task automatic fetch_after_write();
		mem_addr_t base;
		base = 18'h2_0100;
		for (int i = 0; i < 4; i++)
			exe_store(base + mem_addr_t'(i), mem_word_t'(16'hc0de ^ (i << 4)));
		for (int i = 3; i >= 0; i--)
			fetch_load(base + mem_addr_t'(i));
	endtask

	task automatic priority_tie();
		@(posedge clk);
		exe_addr   <= 18'h0_1234;
		exe_write  <= 1'b0;
		exe_tag    <= exe_tag + 1'b1;
		fetch_addr <= 18'h2_0102;
		fetch_tag  <= fetch_tag + 1'b1;
		@(negedge clk);
		while (!fetch_done)
			@(negedge clk);
		// Execute must already be served by now
		check_bit("exe_done", exe_done, 1'b1);
		check_word("exe_rdata", exe_rdata, shadow[18'h0_1234]);
		check_word("fetch_data", fetch_data, shadow[18'h2_0102]);
	endtask

	task automatic random_sweep();
		mem_addr_t addr;
		mem_word_t data;
		int        idx;
		for (int n = 0; n < 64; n++) begin
			if (written.size() == 0 || take_bits(1) == 32'd1) begin
				addr = mem_addr_t'(take_bits(addr_width));
				data = mem_word_t'(take_bits(data_width));
				exe_store(addr, data);
			end else begin
				idx  = int'(take_bits(6)) % written.size();
				addr = written[idx];
				if (take_bits(1) == 32'd1)
					fetch_load(addr);
				else
					exe_load(addr);
			end
		end
	endtask

	task automatic idle_quiet();
		repeat (20) begin
			@(negedge clk);
			check_bit("sram_we_n", sram_we_n, 1'b1);
			check_bit("sram_oe_n", sram_oe_n, 1'b1);
			check_bit("fetch_done", fetch_done, 1'b1);
			check_bit("exe_done", exe_done, 1'b1);
		end
	endtask

	initial begin
		rst        <= 1'b0;
		fetch_addr <= '0;
		fetch_tag  <= '0;
		exe_addr   <= '0;
		exe_wdata  <= '0;
		exe_write  <= 1'b0;
		exe_tag    <= '0;
		repeat (8) @(posedge clk);
		rst <= 1'b1;

		reset_state();
		exe_write_read();
		fetch_after_write();
		priority_tie();
		random_sweep();
		idle_quiet();

		$display("all tests passed");
		$finish;
	end

endmodule

// File: testbench/sram_model.sv
module sram_model import sram_pkg::*; (
	input  mem_addr_t      sram_addr,
	inout  wire mem_word_t sram_data,
	input  logic           sram_en_n,
	input  logic           sram_oe_n,
	input  logic           sram_we_n
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int depth = 1 << addr_width;

	mem_word_t mem [0:depth-1];

	// Power-up contents that depend on every address bit
	function automatic mem_word_t fill_word(input mem_addr_t a);
		return a[15:0] ^ a[17:2] ^ 16'h5a3c;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////////////////////

	// Address and data are settled a full phase before the write strobe falls
	initial begin
		for (int i = 0; i < depth; i++)
			mem[mem_addr_t'(i)] = fill_word(mem_addr_t'(i));
		forever begin
			@(negedge sram_we_n);
			if (!sram_en_n)
				mem[sram_addr] = sram_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read port
	////////////////////////////////////////////////////////////////////////////

	// Outputs driven while selected and output enabled but not writing
	assign sram_data = (!sram_en_n && !sram_oe_n && sram_we_n) ? mem[sram_addr] : 'z;

endmodule

// File: source/sram_ctrl_top.sv
module sram_ctrl_top import sram_pkg::*; (
	input  logic           clk,
	input  logic           rst,

	// Instruction fetch port
	input  mem_addr_t      fetch_addr,
	input  req_tag_t       fetch_tag,
	output mem_word_t      fetch_data,
	output logic           fetch_done,

	// Execute port
	input  mem_addr_t      exe_addr,
	input  mem_word_t      exe_wdata,
	input  logic           exe_write,
	input  req_tag_t       exe_tag,
	output mem_word_t      exe_rdata,
	output logic           exe_done,

	// SRAM pins
	output mem_addr_t      sram_addr,
	inout  wire mem_word_t sram_data,
	output logic           sram_en_n,
	output logic           sram_oe_n,
	output logic           sram_we_n
);

	logic      start;
	logic      busy;
	logic      finish;
	logic      acc_write;
	mem_addr_t acc_addr;
	mem_word_t acc_wdata;
	mem_word_t acc_rdata;

	sram_port_arbiter i_arbiter (
		.clk        (clk),
		.rst        (rst),
		.fetch_addr (fetch_addr),
		.fetch_tag  (fetch_tag),
		.fetch_data (fetch_data),
		.fetch_done (fetch_done),
		.exe_addr   (exe_addr),
		.exe_wdata  (exe_wdata),
		.exe_write  (exe_write),
		.exe_tag    (exe_tag),
		.exe_rdata  (exe_rdata),
		.exe_done   (exe_done),
		.busy       (busy),
		.finish     (finish),
		.acc_rdata  (acc_rdata),
		.start      (start),
		.acc_addr   (acc_addr),
		.acc_wdata  (acc_wdata),
		.acc_write  (acc_write)
	);

	sram_sequencer i_sequencer (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.acc_addr  (acc_addr),
		.acc_wdata (acc_wdata),
		.acc_write (acc_write),
		.busy      (busy),
		.finish    (finish),
		.acc_rdata (acc_rdata),
		.sram_addr (sram_addr),
		.sram_en_n (sram_en_n),
		.sram_oe_n (sram_oe_n),
		.sram_we_n (sram_we_n),
		.sram_data (sram_data)
	);

endmodule

// File: source/sram_sequencer.sv
module sram_sequencer import sram_pkg::*; (
	input  logic           clk,
	input  logic           rst,

	// Access from the arbiter
	input  logic           start,
	input  mem_addr_t      acc_addr,
	input  mem_word_t      acc_wdata,
	input  logic           acc_write,
	output logic           busy,
	output logic           finish,
	output mem_word_t      acc_rdata,

	// SRAM pins
	output mem_addr_t      sram_addr,
	output logic           sram_en_n,
	output logic           sram_oe_n,
	output logic           sram_we_n,
	inout  wire mem_word_t sram_data
);

	////////////////////////////////////////////////////////////////////////////
	// Phase divider
	////////////////////////////////////////////////////////////////////////////

	logic [phase_width-1:0] cnt;
	logic                   phase_end;

	assign phase_end = (cnt == phase_width'(phase_cycles - 1));

	// Free running, so an access waits for the next boundary
	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			cnt <= '0;
		else if (phase_end)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Latched access
	////////////////////////////////////////////////////////////////////////////

	mem_addr_t addr_q;
	mem_word_t wdata_q;
	logic      wr_q;
	logic      pending_q;

	always_ff @(posedge clk) begin
		if (start) begin
			addr_q  <= acc_addr;
			wdata_q <= acc_wdata;
			wr_q    <= acc_write;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Bus state machine
	////////////////////////////////////////////////////////////////////////////

	bus_state_t state;
	bus_state_t state_next;
	logic       go_write;

	// Direction is taken from the port itself on the start cycle
	assign go_write = start ? acc_write : wr_q;

	always_comb begin
		state_next = state;
		if (phase_end) begin
			case (state)
				st_idle: begin
					if (start || pending_q)
						state_next = go_write ? st_wr_setup : st_rd_setup;
				end
				st_rd_setup:   state_next = st_rd_strobe;
				st_rd_strobe:  state_next = st_rd_capture;
				st_rd_capture: state_next = st_idle;
				st_wr_setup:   state_next = st_wr_strobe;
				st_wr_strobe:  state_next = st_wr_hold;
				st_wr_hold:    state_next = st_idle;
				default:       state_next = st_idle;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state     <= st_idle;
			pending_q <= 1'b0;
		end else begin
			state <= state_next;
			// Start waits here until the phase boundary
			if (state == st_idle && state_next != st_idle)
				pending_q <= 1'b0;
			else if (start)
				pending_q <= 1'b1;
		end
	end

	assign busy   = pending_q || (state != st_idle);
	assign finish = phase_end && (state == st_rd_capture || state == st_wr_hold);

	////////////////////////////////////////////////////////////////////////////
	// Strobes and data bus
	////////////////////////////////////////////////////////////////////////////

	logic drive;

	// Chip stays selected
	assign sram_en_n = 1'b0;
	assign sram_addr = addr_q;
	assign sram_oe_n = !(state == st_rd_strobe || state == st_rd_capture);
	assign sram_we_n = !(state == st_wr_strobe || state == st_wr_hold);

	assign drive     = (state == st_wr_setup) || (state == st_wr_strobe) ||
	                   (state == st_wr_hold);
	assign sram_data = drive ? wdata_q : 'z;

	// Sampled on each edge into or inside capture so the last one lands before finish
	always_ff @(posedge clk) begin
		if (state_next == st_rd_capture)
			acc_rdata <= sram_data;
	end

	a_oe_we_exclusive: assert property (@(posedge clk) disable iff (!rst)
		!(!sram_oe_n && !sram_we_n));

	// Bus driven only for a latched write
	a_drive_write_only: assert property (@(posedge clk) disable iff (!rst)
		drive |-> wr_q);

endmodule

// File: source/sram_port_arbiter.sv
module sram_port_arbiter import sram_pkg::*; (
	input  logic      clk,
	input  logic      rst,

	// Read-only instruction fetch port
	input  mem_addr_t fetch_addr,
	input  req_tag_t  fetch_tag,
	output mem_word_t fetch_data,
	output logic      fetch_done,

	// Execute port for reads and writes
	input  mem_addr_t exe_addr,
	input  mem_word_t exe_wdata,
	input  logic      exe_write,
	input  req_tag_t  exe_tag,
	output mem_word_t exe_rdata,
	output logic      exe_done,

	// Towards the sequencer
	input  logic      busy,
	input  logic      finish,
	input  mem_word_t acc_rdata,
	output logic      start,
	output mem_addr_t acc_addr,
	output mem_word_t acc_wdata,
	output logic      acc_write
);

	// Last tag served for each port
	req_tag_t fetch_served;
	req_tag_t exe_served;

	logic fetch_pend;
	logic exe_pend;
	logic active;
	logic owner_exe;
	logic issue;

	assign fetch_pend = (fetch_tag != fetch_served);
	assign exe_pend   = (exe_tag != exe_served);

	assign fetch_done = !fetch_pend;
	assign exe_done   = !exe_pend;

	// One access in flight at a time and execute wins a tie
	assign issue = !active && !busy && (exe_pend || fetch_pend);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			start        <= 1'b0;
			active       <= 1'b0;
			owner_exe    <= 1'b0;
			fetch_served <= '0;
			exe_served   <= '0;
		end else begin
			start <= 1'b0;
			if (finish) begin
				active <= 1'b0;
				// Tag is still held by the port, so copy it straight across
				if (owner_exe)
					exe_served <= exe_tag;
				else
					fetch_served <= fetch_tag;
			end else if (issue) begin
				start     <= 1'b1;
				active    <= 1'b1;
				owner_exe <= exe_pend;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			acc_addr  <= exe_pend ? exe_addr : fetch_addr;
			acc_wdata <= exe_wdata;
			acc_write <= exe_pend && exe_write;
		end
		// Read word goes to whichever port owns the access
		if (finish && !acc_write) begin
			if (owner_exe)
				exe_rdata <= acc_rdata;
			else
				fetch_data <= acc_rdata;
		end
	end

	// Sequencer must have dropped busy before a new access is handed over
	a_start_not_busy: assert property (@(posedge clk) disable iff (!rst)
		start |-> !busy);

endmodule

// File: source/sram_pkg.sv
package sram_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths of the external SRAM and the request tags
	////////////////////////////////////////////////////////////////////////////

	localparam int addr_width = 18;
	localparam int data_width = 16;
	localparam int tag_width  = 8;

	////////////////////////////////////////////////////////////////////////////
	// Bus timing
	////////////////////////////////////////////////////////////////////////////

	// Clock cycles spent in every bus state
	localparam int phase_cycles = 2;
	// Phase divider width is at least one bit
	localparam int phase_width  = (phase_cycles > 1) ? $clog2(phase_cycles) : 1;

	typedef logic [addr_width-1:0] mem_addr_t;
	typedef logic [data_width-1:0] mem_word_t;
	typedef logic [tag_width-1:0]  req_tag_t;

	// A read runs setup, strobe and capture and a write runs setup, strobe and hold
	typedef enum logic [2:0] {
		st_idle       = 3'd0,
		st_rd_setup   = 3'd1,
		st_rd_strobe  = 3'd2,
		st_rd_capture = 3'd3,
		st_wr_setup   = 3'd4,
		st_wr_strobe  = 3'd5,
		st_wr_hold    = 3'd6
	} bus_state_t;

endpackage
